/* source/conv_buf_pkg.sv */
package conv_buf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Element and lane sizing

    localparam int data_width      = 16; // Half precision
    localparam int para_x          = 3;
    localparam int para_y          = 3;
    localparam int para_kernel     = 2;  // Weight banks
    localparam int kernel_size_max = 3;
    localparam int kernel_area     = kernel_size_max * kernel_size_max;

    ////////////////////////////////////////////////////////////////////////////
    // Buffer geometry

    localparam int fm_depth      = 18;
    localparam int fm_addr_width = $clog2(fm_depth);
    localparam int wt_depth      = 32;
    localparam int wt_half       = wt_depth / 2;     // Upper half base
    localparam int wt_addr_width = $clog2(wt_depth);
    localparam int wt_init_slots = 4;                // Kernel slots set by init

    localparam int fm_word_width = para_x * para_y * data_width;
    localparam int wt_word_width = kernel_area * data_width;

    ////////////////////////////////////////////////////////////////////////////
    // Write ports

    // Feature-map buffer write
    typedef struct packed {
        logic                     we;
        logic [fm_addr_width-1:0] addr;
        logic [fm_word_width-1:0] data;
    } fm_wr_t;

    // One address per bank, data and strobe shared by all banks
    typedef struct packed {
        logic                                      we;
        logic [para_kernel-1:0][wt_addr_width-1:0] addr;
        logic [wt_word_width-1:0]                  data;
    } wt_wr_t;

endpackage

/* source/buffer_ram.sv */
`timescale 1ns/1ps

// Simple dual-port buffer: one write port, one registered read port
module buffer_ram #(
    parameter int depth = 32,
    parameter int width = 144
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [width-1:0]         wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [width-1:0]         rd_data
);

    logic [width-1:0] mem [depth];

    // Write side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, one cycle from address to data
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr]; // Old word on a same-cycle write
    end

endmodule

/* source/buffer_init_ctrl.sv */
`timescale 1ns/1ps

module buffer_init_ctrl import conv_buf_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      init,
    input  logic [data_width-1:0]                     fm_fill,
    input  logic [data_width-1:0]                     wt_fill,
    input  logic                                      update_weight_ram,
    input  logic [para_kernel-1:0][wt_addr_width-1:0] update_weight_addr,
    output logic                                      start,
    output fm_wr_t                                    fm_wr,
    output wt_wr_t                                    wt_wr,
    output logic                                      fm_loading,
    output logic                                      wt_loading
);

    logic init_q;
    logic fill_go;

    logic                     fm_busy;
    logic                     fm_phase; // 0 write step, 1 idle step
    logic                     fm_fin;
    logic [fm_addr_width-1:0] fm_cnt;
    logic                     fm_step;
    logic                     fm_we;
    logic [fm_addr_width-1:0] fm_addr;
    logic [fm_word_width-1:0] fm_data;

    logic                                      wt_phase;
    logic                                      wt_upd; // Current write is an update
    logic [2:0]                                wt_slot;
    logic [wt_addr_width-1:0]                  wt_slot_addr;
    logic                                      wt_step;
    logic                                      upd_go;
    logic                                      wt_we;
    logic [para_kernel-1:0][wt_addr_width-1:0] wt_addr;
    logic [wt_word_width-1:0]                  wt_data;

    ////////////////////////////////////////////////////////////////////////////
    // Init edge detect

    always_ff @(posedge clk) begin
        if (rst) begin
            init_q <= 1'b0;
        end else begin
            init_q <= init;
        end
    end

    // New rise starts both fills unless the fm fill still runs
    assign fill_go = init & ~init_q & ~fm_busy;

    // Start level follows init once the fill has finished
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else if (!init) begin
            start <= 1'b0;
        end else if (fm_fin) begin
            start <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Feature-map fill

    // Write step of the half-rate sequence
    assign fm_step = fill_go | (fm_busy & ~fm_phase & (fm_cnt != fm_addr_width'(fm_depth)));

    always_ff @(posedge clk) begin
        if (rst) begin
            fm_busy    <= 1'b0;
            fm_phase   <= 1'b0;
            fm_cnt     <= '0;
            fm_fin     <= 1'b0;
            fm_loading <= 1'b0;
            fm_we      <= 1'b0;
        end else begin
            fm_fin <= 1'b0;
            if (fm_step) begin
                fm_busy    <= 1'b1;
                fm_loading <= 1'b1;
                fm_we      <= 1'b1;
                fm_phase   <= 1'b1;
                fm_cnt     <= fm_cnt + 1'b1;
            end else if (fm_busy && fm_phase) begin
                fm_we    <= 1'b0;
                fm_phase <= 1'b0;
                if (fm_cnt == fm_addr_width'(fm_depth)) begin
                    fm_loading <= 1'b0; // Last word written
                end
            end else if (fm_busy) begin
                fm_busy <= 1'b0; // Trailing idle step
                fm_cnt  <= '0;
                fm_fin  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fm_step) begin
            fm_addr <= fm_cnt;
            fm_data <= {(para_x * para_y){fm_fill}}; // Same value in every lane
        end
    end

    assign fm_wr = '{we: fm_we, addr: fm_addr, data: fm_data};

    ////////////////////////////////////////////////////////////////////////////
    // Weight fill

    // Fixed kernel slots in the lower and upper bank halves
    always_comb begin
        case (wt_slot)
            3'd0:    wt_slot_addr = '0;
            3'd1:    wt_slot_addr = wt_addr_width'(kernel_area);
            3'd2:    wt_slot_addr = wt_addr_width'(wt_half);
            3'd3:    wt_slot_addr = wt_addr_width'(wt_half + kernel_area);
            default: wt_slot_addr = '0;
        endcase
    end

    // Slot write step on the first slot or a later even cycle
    assign wt_step = fill_go | (wt_loading & ~wt_upd & ~wt_phase);

    ////////////////////////////////////////////////////////////////////////////
    // Weight update

    assign upd_go = update_weight_ram & ~init & ~wt_loading;

    always_ff @(posedge clk) begin
        if (rst) begin
            wt_loading <= 1'b0;
            wt_phase   <= 1'b0;
            wt_upd     <= 1'b0;
            wt_slot    <= '0;
            wt_we      <= 1'b0;
        end else if (wt_step) begin
            wt_loading <= 1'b1;
            wt_upd     <= 1'b0; // Init fill wins over an update
            wt_we      <= 1'b1;
            wt_phase   <= 1'b1;
            wt_slot    <= wt_slot + 1'b1;
        end else if (wt_loading && wt_upd) begin
            wt_loading <= 1'b0;
            wt_upd     <= 1'b0;
            wt_we      <= 1'b0;
        end else if (wt_loading) begin
            wt_we    <= 1'b0;
            wt_phase <= 1'b0;
            if (wt_slot == 3'(wt_init_slots)) begin
                wt_loading <= 1'b0;
                wt_slot    <= '0;
            end
        end else if (upd_go) begin
            wt_loading <= 1'b1; // Single write cycle
            wt_upd     <= 1'b1;
            wt_we      <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wt_step) begin
            wt_addr <= {para_kernel{wt_slot_addr}}; // Same slot in every bank
        end else if (upd_go) begin
            wt_addr <= update_weight_addr;
        end
        if (wt_step || upd_go) begin
            wt_data <= {kernel_area{wt_fill}}; // Fill and update both write wt_fill
        end
    end

    assign wt_wr = '{we: wt_we, addr: wt_addr, data: wt_data};

endmodule

/* source/conv_buf_top.sv */
`timescale 1ns/1ps

module conv_buf_top import conv_buf_pkg::*; (
    input  logic                                      clk,
    input  logic                                      rst,

    // Loader control
    input  logic                                      init,
    input  logic [data_width-1:0]                     fm_fill,
    input  logic [data_width-1:0]                     wt_fill,
    input  logic                                      update_weight_ram,
    input  logic [para_kernel-1:0][wt_addr_width-1:0] update_weight_addr,
    output logic                                      start,
    output logic                                      fm_loading,
    output logic                                      wt_loading,

    // Observation reads
    input  logic [fm_addr_width-1:0]                  fm_rd_addr,
    output logic [fm_word_width-1:0]                  fm_rd_data,
    input  logic [para_kernel-1:0][wt_addr_width-1:0] wt_rd_addr,
    output logic [para_kernel-1:0][wt_word_width-1:0] wt_rd_data
);

    fm_wr_t fm_wr;
    wt_wr_t wt_wr;

    ////////////////////////////////////////////////////////////////////////////
    // Loader

    buffer_init_ctrl loader (
        .clk                (clk),
        .rst                (rst),
        .init               (init),
        .fm_fill            (fm_fill),
        .wt_fill            (wt_fill),
        .update_weight_ram  (update_weight_ram),
        .update_weight_addr (update_weight_addr),
        .start              (start),
        .fm_wr              (fm_wr),
        .wt_wr              (wt_wr),
        .fm_loading         (fm_loading),
        .wt_loading         (wt_loading)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Feature-map buffer

    buffer_ram #(
        .depth (fm_depth),
        .width (fm_word_width)
    ) fm_ram (
        .clk     (clk),
        .we      (fm_wr.we),
        .wr_addr (fm_wr.addr),
        .wr_data (fm_wr.data),
        .rd_addr (fm_rd_addr),
        .rd_data (fm_rd_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Weight banks

    // Each bank takes its own address, strobe and data are shared
    for (genvar b = 0; b < para_kernel; b++) begin : g_wt
        buffer_ram #(
            .depth (wt_depth),
            .width (wt_word_width)
        ) wt_bank (
            .clk     (clk),
            .we      (wt_wr.we),
            .wr_addr (wt_wr.addr[b]),
            .wr_data (wt_wr.data),
            .rd_addr (wt_rd_addr[b]),
            .rd_data (wt_rd_data[b]) // Bank b slice of the packed output
        );
    end

endmodule

/* verif/conv_buf_tb.sv */
`timescale 1ns/1ps

module conv_buf_tb import conv_buf_pkg::*; ();

    localparam int    timeout_cycles = 200;
    localparam int    fm_lanes       = para_x * para_y;
    localparam int    start_edge     = 2 * fm_depth + 1; // Last fm write at 2*fm_depth-1
    localparam string trace_path     = "verif/conv_buf_trace.txt";

    logic                                      clk;
    logic                                      rst;
    logic                                      init;
    logic [data_width-1:0]                     fm_fill;
    logic [data_width-1:0]                     wt_fill;
    logic                                      update_weight_ram;
    logic [para_kernel-1:0][wt_addr_width-1:0] update_weight_addr;
    logic [fm_addr_width-1:0]                  fm_rd_addr;
    logic [para_kernel-1:0][wt_addr_width-1:0] wt_rd_addr;
    logic                                      start;
    logic                                      fm_loading;
    logic                                      wt_loading;
    logic [fm_word_width-1:0]                  fm_rd_data;
    logic [para_kernel-1:0][wt_word_width-1:0] wt_rd_data;

    int                    fd;
    int                    errors;
    int                    checks;
    int                    test_errs;
    int                    tests_run;
    int                    tests_failed;
    int                    cur_test;
    logic                  timed_out;
    logic [data_width-1:0] level_wt_fill; // Fill value of the last init

    conv_buf_top dut0 (
        .clk                (clk),
        .rst                (rst),
        .init               (init),
        .fm_fill            (fm_fill),
        .wt_fill            (wt_fill),
        .update_weight_ram  (update_weight_ram),
        .update_weight_addr (update_weight_addr),
        .start              (start),
        .fm_loading         (fm_loading),
        .wt_loading         (wt_loading),
        .fm_rd_addr         (fm_rd_addr),
        .fm_rd_data         (fm_rd_data),
        .wt_rd_addr         (wt_rd_addr),
        .wt_rd_data         (wt_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bookkeeping

    task automatic count_error();
        errors++;
        test_errs++;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic report_bad_line(input string cmd);
        $display("Trace line for %s is missing arguments", cmd);
        count_error();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command handlers entered and left on a falling edge

    // Weight fill still running, or the fm fill too when asked for
    function automatic logic fill_busy(input logic with_fm);
        return wt_loading !== 1'b0 || (with_fm && fm_loading !== 1'b0);
    endfunction

    // Reads wait for the fill of their own buffer
    task automatic wait_idle(input logic with_fm);
        int cyc;
        cyc = 0;
        while (fill_busy(with_fm) && cyc < timeout_cycles) begin
            @(negedge clk);
            cyc++;
        end
        if (fill_busy(with_fm)) begin
            $display("Timed out waiting for the buffer fills to finish");
            timed_out = 1'b1;
            count_error();
        end
    endtask

    task automatic raise_init(input logic [data_width-1:0] fm, input logic [data_width-1:0] wt,
                              input int hold);
        int cyc;
        int i;
        fm_fill       = fm;
        wt_fill       = wt;
        level_wt_fill = wt;
        init          = 1'b1;
        cyc           = 0;
        if (hold == 0) begin
            @(negedge clk); // Rise seen and fills running
        end else begin
            while (start !== 1'b1 && cyc < timeout_cycles) begin
                @(negedge clk);
                cyc++;
            end
            checks++;
            if (start !== 1'b1) begin
                $display("Timed out waiting for start after init rose");
                timed_out = 1'b1;
                count_error();
            end else if (cyc - 1 != start_edge) begin
                $display("[ERROR] start rise edge: expected %h, got %h", start_edge, cyc - 1);
                count_error();
            end
            for (i = 0; i < hold; i++) begin
                @(negedge clk);
                checks++;
                if (start !== 1'b1) begin
                    $display("[ERROR] start while init held: expected %h, got %h", 1'b1, start);
                    count_error();
                end
            end
        end
    endtask

    task automatic drop_init();
        init = 1'b0;
        @(negedge clk);
        checks++;
        if (start !== 1'b0) begin
            $display("[ERROR] start after init fell: expected %h, got %h", 1'b0, start);
            count_error();
        end
    endtask

    task automatic pulse_update(input int addr0, input int addr1, input logic [data_width-1:0] wt);
        update_weight_addr[0] = wt_addr_width'(addr0);
        update_weight_addr[1] = wt_addr_width'(addr1);
        wt_fill               = wt;
        update_weight_ram     = 1'b1;
        @(negedge clk);
        update_weight_ram = 1'b0;
        wt_fill           = level_wt_fill; // A running fill keeps its own value
        wait_idle(1'b0);
    endtask

    // Start must stay low through idle cycles while init is low
    task automatic run_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            if (init === 1'b0) begin
                checks++;
                if (start !== 1'b0) begin
                    $display("[ERROR] start with init low: expected %h, got %h", 1'b0, start);
                    count_error();
                end
            end
        end
    endtask

    task automatic read_fm(input int addr, input logic [data_width-1:0] exp);
        int lane;
        wait_idle(1'b1);
        fm_rd_addr = fm_addr_width'(addr);
        @(negedge clk); // One cycle read latency
        for (lane = 0; lane < fm_lanes; lane++) begin
            checks++;
            if (fm_rd_data[lane*data_width +: data_width] !== exp) begin
                $display("[ERROR] fm_rd_data addr %0d lane %0d: expected %h, got %h",
                         addr, lane, exp, fm_rd_data[lane*data_width +: data_width]);
                count_error();
            end
        end
    endtask

    task automatic read_wt(input int bank, input int addr, input logic [data_width-1:0] exp);
        int lane;
        wait_idle(1'b0);
        wt_rd_addr[bank] = wt_addr_width'(addr);
        @(negedge clk);
        for (lane = 0; lane < kernel_area; lane++) begin
            checks++;
            if (wt_rd_data[bank][lane*data_width +: data_width] !== exp) begin
                $display("[ERROR] wt_rd_data bank %0d addr %0d lane %0d: expected %h, got %h",
                         bank, addr, lane, exp, wt_rd_data[bank][lane*data_width +: data_width]);
                count_error();
            end
        end
    endtask

    task automatic run_command(input string cmd);
        int          code;
        int          n0;
        int          n1;
        logic [31:0] h0;
        logic [31:0] h1;
        if (cmd == "INIT") begin
            code = $fscanf(fd, "%h %h %d", h0, h1, n0);
            if (code != 3) report_bad_line(cmd);
            else raise_init(h0[data_width-1:0], h1[data_width-1:0], n0);
        end else if (cmd == "DROP") begin
            drop_init();
        end else if (cmd == "UPD") begin
            code = $fscanf(fd, "%d %d %h", n0, n1, h0);
            if (code != 3) report_bad_line(cmd);
            else pulse_update(n0, n1, h0[data_width-1:0]);
        end else if (cmd == "RFM") begin
            code = $fscanf(fd, "%d %h", n0, h0);
            if (code != 2) report_bad_line(cmd);
            else read_fm(n0, h0[data_width-1:0]);
        end else if (cmd == "RWT") begin
            code = $fscanf(fd, "%d %d %h", n0, n1, h0);
            if (code != 3) report_bad_line(cmd);
            else read_wt(n0, n1, h0[data_width-1:0]);
        end else if (cmd == "WAIT") begin
            code = $fscanf(fd, "%d", n0);
            if (code != 1) report_bad_line(cmd);
            else run_cycles(n0);
        end else begin
            $display("Unknown trace command %s", cmd);
            count_error();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        int                 code;
        int                 test_id;
        string              cmd;
        logic [8*128-1:0]   skip_line;
        logic               done;
        rst                = 1'b1;
        init               = 1'b0;
        fm_fill            = '0;
        wt_fill            = '0;
        update_weight_ram  = 1'b0;
        update_weight_addr = '0;
        fm_rd_addr         = '0;
        wt_rd_addr         = '0;
        level_wt_fill      = '0;
        errors             = 0;
        checks             = 0;
        test_errs          = 0;
        tests_run          = 0;
        tests_failed       = 0;
        timed_out          = 1'b0;
        done               = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state of the loader outputs
        cur_test = 1;
        @(negedge clk);
        checks += 3;
        if (start !== 1'b0) begin
            $display("[ERROR] start after reset: expected %h, got %h", 1'b0, start);
            count_error();
        end
        if (fm_loading !== 1'b0) begin
            $display("[ERROR] fm_loading after reset: expected %h, got %h", 1'b0, fm_loading);
            count_error();
        end
        if (wt_loading !== 1'b0) begin
            $display("[ERROR] wt_loading after reset: expected %h, got %h", 1'b0, wt_loading);
            count_error();
        end
        close_test();
        cur_test = 0;

        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", trace_path);
            errors++;
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", cmd);
                if (code != 1) begin
                    done = 1'b1; // End of trace
                end else if (cmd == "#") begin
                    code = $fgets(skip_line, fd);
                end else begin
                    code = $fscanf(fd, "%d", test_id);
                    if (test_id != cur_test) begin
                        if (cur_test != 0) close_test();
                        cur_test = test_id;
                    end
                    run_command(cmd);
                    if (timed_out) done = 1'b1;
                end
            end
            $fclose(fd);
            if (cur_test != 0) close_test();
        end

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verif/conv_buf_trace.txt */
# Columns: command, test number, then arguments; fill values and expected words in hex
# INIT t fm wt hold | DROP t | UPD t addr0 addr1 wt | RFM t addr exp | RWT t bank addr exp | WAIT t n
# First fill, start held for six cycles
INIT 2 3c00 4000 6
RFM 2 0 3c00
RFM 2 1 3c00
RFM 2 2 3c00
RFM 2 3 3c00
RFM 2 4 3c00
RFM 2 5 3c00
RFM 2 6 3c00
RFM 2 7 3c00
RFM 2 8 3c00
RFM 2 9 3c00
RFM 2 10 3c00
RFM 2 11 3c00
RFM 2 12 3c00
RFM 2 13 3c00
RFM 2 14 3c00
RFM 2 15 3c00
RFM 2 16 3c00
RFM 2 17 3c00
# Kernel slots of both banks, then a refill over an updated word
RWT 3 0 0 4000
RWT 3 0 9 4000
RWT 3 0 16 4000
RWT 3 0 25 4000
RWT 3 1 0 4000
RWT 3 1 9 4000
RWT 3 1 16 4000
RWT 3 1 25 4000
DROP 3
UPD 3 3 3 4d00
INIT 3 3e00 4200 4
RWT 3 0 0 4200
RWT 3 0 9 4200
RWT 3 0 16 4200
RWT 3 0 25 4200
RWT 3 1 0 4200
RWT 3 1 9 4200
RWT 3 1 16 4200
RWT 3 1 25 4200
RWT 3 0 3 4d00
RWT 3 1 3 4d00
# Start falls one cycle after init
DROP 4
WAIT 4 5
# Per-bank update addresses, then an update during a weight fill
UPD 5 5 5 4400
UPD 5 12 12 4400
UPD 5 5 12 4500
RWT 5 0 5 4500
RWT 5 1 5 4400
RWT 5 1 12 4500
RWT 5 0 12 4400
INIT 5 3800 3a00 0
DROP 5
WAIT 5 1
UPD 5 3 3 4600
RWT 5 0 3 4d00
RWT 5 1 3 4d00
RWT 5 0 9 3a00
RWT 5 1 25 3a00
# Fill dropped early still completes
WAIT 6 40
RFM 6 0 3800
RFM 6 1 3800
RFM 6 2 3800
RFM 6 3 3800
RFM 6 4 3800
RFM 6 5 3800
RFM 6 6 3800
RFM 6 7 3800
RFM 6 8 3800
RFM 6 9 3800
RFM 6 10 3800
RFM 6 11 3800
RFM 6 12 3800
RFM 6 13 3800
RFM 6 14 3800
RFM 6 15 3800
RFM 6 16 3800
RFM 6 17 3800

/* filelist.f */
source/conv_buf_pkg.sv
source/buffer_ram.sv
source/buffer_init_ctrl.sv
source/conv_buf_top.sv
verif/conv_buf_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

top=conv_buf_tb
build_dir=obj_dir
log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$top" --Mdir "$build_dir" -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$build_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints its verdict on a line of its own
if grep -q "^TESTS PASSED$" "$log"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $log"
    exit 1
fi
